// ==== source/ex_pkg.sv ====
// Execute stage package with word, operator and write-port types shared by all units
package ex_pkg;

  // ISA-fixed widths
  localparam int unsigned WORD_W  = 32;
  localparam int unsigned RADDR_W = 6;

  // Shift amount taken from operand b
  localparam int unsigned SHIFT_W = 5;

  // Multiplier consumes operand b one half per step
  localparam int unsigned HALF_W  = 16;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [RADDR_W-1:0] reg_addr_t;

  //////////////////////////////
  // ALU operators
  //////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_GE   = 4'd12,
    ALU_GEU  = 4'd13
  } alu_op_e;

  //////////////////////////////
  // Port bundles
  //////////////////////////////

  // Operand c is the jump target, unused by the datapath
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;
  } alu_req_t;

  typedef struct packed {
    word_t a;
    word_t b;
  } mult_req_t;

  // Destination as decoded in ID
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
  } rf_dest_t;

  // Register file write, forwarding and load port alike
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_wr_t;

endpackage

// ==== source/ex_alu.sv ====
// Integer ALU for the execute stage with add, logic, shift, compare and branch decision
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     enable_i,
  input  alu_req_t req_i,
  output word_t    result_o,
  output logic     cmp_o
);

  logic [SHIFT_W-1:0] shamt;
  logic               is_eq;
  logic               is_lt;
  logic               is_ltu;
  word_t              add_res;
  word_t              sub_res;

  // Only the low bits of b count for shifts
  assign shamt = req_i.b[SHIFT_W-1:0];

  assign add_res = req_i.a + req_i.b;
  assign sub_res = req_i.a - req_i.b;

  //////////////////////////////
  // Comparator
  //////////////////////////////
  assign is_eq  = (req_i.a == req_i.b);
  assign is_lt  = ($signed(req_i.a) < $signed(req_i.b));
  assign is_ltu = (req_i.a < req_i.b);

  // Branch condition, also the set-less-than bit
  always_comb begin
    unique case (req_i.op)
      ALU_SLT:  cmp_o = is_lt;
      ALU_SLTU: cmp_o = is_ltu;
      ALU_EQ:   cmp_o = is_eq;
      ALU_NE:   cmp_o = ~is_eq;
      ALU_GE:   cmp_o = ~is_lt;
      ALU_GEU:  cmp_o = ~is_ltu;
      // Not a branch, value is ignored by IF
      default:  cmp_o = is_eq;
    endcase
  end

  //////////////////////////////
  // Result mux
  //////////////////////////////
  always_comb begin
    unique case (req_i.op)
      ALU_ADD: result_o = add_res;
      ALU_SUB: result_o = sub_res;
      ALU_AND: result_o = req_i.a & req_i.b;
      ALU_OR:  result_o = req_i.a | req_i.b;
      ALU_XOR: result_o = req_i.a ^ req_i.b;
      ALU_SLL: result_o = req_i.a << shamt;
      ALU_SRL: result_o = req_i.a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA: result_o = $signed(req_i.a) >>> shamt;
      // Compare operators return the bit zero-extended
      default: result_o = {{($bits(word_t)-1){1'b0}}, cmp_o};
    endcase
  end

  // Decoder must never hand over an undefined operator
  a_legal_op: assert property (
    @(posedge clk) disable iff (!rst_n)
    enable_i |-> req_i.op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                  ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
                                  ALU_EQ, ALU_NE, ALU_GE, ALU_GEU}
  ) else $error("ALU operator out of range");

endmodule

// ==== source/ex_mult.sv ====
// Two-step sequential multiplier returning the low word of a 32x32 product
`timescale 1ns/1ps

module ex_mult import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable_i,
  input  mult_req_t req_i,
  input  logic      ex_ready_i,
  output word_t     result_o,
  output logic      ready_o,
  output logic      busy_o
);

  typedef enum logic {
    ST_IDLE,
    ST_STEP2
  } mult_state_e;

  mult_state_e state_q;
  word_t       lo_prod_q;
  word_t       lo_prod;
  word_t       hi_prod;

  //////////////////////////////
  // Partial products
  //////////////////////////////

  // Step one product of a and the low half of b
  assign lo_prod = req_i.a * req_i.b[HALF_W-1:0];

  // Step two product of a and the high half of b
  assign hi_prod = req_i.a * req_i.b[2*HALF_W-1:HALF_W];

  // Upper 32 bits drop out
  assign result_o = lo_prod_q + (hi_prod << HALF_W);

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  // First step stalls the stage
  assign busy_o  = (state_q == ST_IDLE) & enable_i;
  assign ready_o = ((state_q == ST_IDLE) & ~enable_i) | (state_q == ST_STEP2);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (enable_i) begin
            state_q <= ST_STEP2;
          end
        end
        // Result waits here while the stage is stalled
        ST_STEP2: begin
          if (ex_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Low partial product captured in the first step
  always_ff @(posedge clk) begin
    if (busy_o) begin
      lo_prod_q <= lo_prod;
    end
  end

  // Second step reuses the live operands
  a_ops_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    busy_o |=> $stable(req_i)
  ) else $error("Multiplier operands changed between steps");

endmodule

// ==== source/ex_wb_ports.sv ====
// Forwarding write mux, EX/WB pipeline register and load write port
`timescale 1ns/1ps

module ex_wb_ports import ex_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ex_valid_i,
  input  logic     wb_ready_i,
  input  logic     alu_en_i,
  input  logic     mult_en_i,
  input  logic     csr_access_i,
  input  word_t    alu_result_i,
  input  word_t    mult_result_i,
  input  word_t    csr_rdata_i,
  input  word_t    lsu_rdata_i,
  input  rf_dest_t alu_dest_i,
  input  rf_dest_t lsu_dest_i,
  input  logic     lsu_err_i,
  output rf_wr_t   fw_o,
  output rf_wr_t   wb_o
);

  logic      lsu_we;
  logic      lsu_we_q;
  reg_addr_t lsu_addr_q;

  //////////////////////////////
  // Forwarding port
  //////////////////////////////
  always_comb begin
    fw_o.we   = alu_dest_i.we;
    fw_o.addr = alu_dest_i.addr;
    fw_o.data = '0;
    // Later source wins
    if (alu_en_i) fw_o.data = alu_result_i;
    if (mult_en_i) fw_o.data = mult_result_i;
    if (csr_access_i) fw_o.data = csr_rdata_i;
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  // A faulting load must not write the register file
  assign lsu_we = lsu_dest_i.we & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_i) begin
      lsu_we_q <= lsu_we;
    end else if (wb_ready_i) begin
      // Nothing new arrived, flush the slot
      lsu_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i && lsu_we) begin
      lsu_addr_q <= lsu_dest_i.addr;
    end
  end

  // Load data arrives from the LSU in the WB cycle
  assign wb_o = '{we: lsu_we_q, addr: lsu_addr_q, data: lsu_rdata_i};

  // Stage valid already includes WB ready
  a_valid_needs_wb: assert property (
    @(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i
  ) else $error("EX valid raised while WB stalls");

endmodule

// ==== source/ex_stage.sv ====
// Execute stage top level with ALU, multiplier, write ports and stall control
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // From ID
  input  logic      alu_en_i,
  input  alu_req_t  alu_req_i,
  input  logic      mult_en_i,
  input  mult_req_t mult_req_i,
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      lsu_en_i,
  input  logic      branch_in_ex_i,
  input  rf_dest_t  alu_dest_i,
  input  rf_dest_t  lsu_dest_i,

  // From LSU
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,

  // From WB
  input  logic      wb_ready_i,

  // Register file ports
  output rf_wr_t    fw_o,
  output rf_wr_t    wb_o,

  // To IF
  output word_t     jump_target_o,
  output logic      branch_decision_o,

  // Stall control
  output logic      mult_multicycle_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  logic  alu_cmp;
  word_t mult_result;
  logic  mult_ready;
  logic  mult_busy;
  logic  ex_ready;
  logic  ex_valid;

  //////////////////////////////
  // ALU
  //////////////////////////////
  ex_alu alu0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable_i (alu_en_i),
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  // Branch target comes in on operand c
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.c;

  //////////////////////////////
  // Multiplier
  //////////////////////////////
  ex_mult mult0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (mult_en_i),
    .req_i      (mult_req_i),
    .ex_ready_i (ex_ready),
    .result_o   (mult_result),
    .ready_o    (mult_ready),
    .busy_o     (mult_busy)
  );

  assign mult_multicycle_o = mult_busy;

  //////////////////////////////
  // Write ports
  //////////////////////////////
  ex_wb_ports wbp0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_valid_i    (ex_valid),
    .wb_ready_i    (wb_ready_i),
    .alu_en_i      (alu_en_i),
    .mult_en_i     (mult_en_i),
    .csr_access_i  (csr_access_i),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .alu_dest_i    (alu_dest_i),
    .lsu_dest_i    (lsu_dest_i),
    .lsu_err_i     (lsu_err_i),
    .fw_o          (fw_o),
    .wb_o          (wb_o)
  );

  //////////////////////////////
  // Ready and valid
  //////////////////////////////

  // Branches resolve here and never reach WB
  assign ex_ready = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;

  // Valid flows right, independent of ready
  assign ex_valid = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                    & mult_ready & lsu_ready_ex_i & wb_ready_i;

  assign ex_ready_o = ex_ready;
  assign ex_valid_o = ex_valid;

endmodule

// ==== dv/ex_stage_tb_table.svh ====
// Stimulus and expected-value table for the execute stage testbench

  task automatic build_table();
    //////////////////////////////
    // ALU operators
    //////////////////////////////
    alu_row("add",  ALU_ADD,  32'h0000_1234, 32'h0000_0f00, 6'd1,  32'h0000_2134);
    alu_row("sub",  ALU_SUB,  32'h0000_0005, 32'h0000_0007, 6'd2,  32'hffff_fffe);
    alu_row("and",  ALU_AND,  32'hf0f0_1234, 32'h0ff0_ff00, 6'd3,  32'h00f0_1200);
    alu_row("or",   ALU_OR,   32'ha000_0005, 32'h0500_0030, 6'd4,  32'ha500_0035);
    alu_row("xor",  ALU_XOR,  32'hffff_0000, 32'h0f0f_0f0f, 6'd5,  32'hf0f0_0f0f);
    // Bit 5 of b set, shift uses only the low five bits
    alu_row("sll",  ALU_SLL,  32'h0000_0003, 32'h0000_0024, 6'd6,  32'h0000_0030);
    alu_row("srl",  ALU_SRL,  32'h8000_0000, 32'h0000_0004, 6'd7,  32'h0800_0000);
    alu_row("sra",  ALU_SRA,  32'h8000_0000, 32'h0000_0004, 6'd33, 32'hf800_0000);
    alu_row("slt",  ALU_SLT,  32'hffff_ffff, 32'h0000_0001, 6'd9,  32'h0000_0001);
    alu_row("sltu", ALU_SLTU, 32'hffff_ffff, 32'h0000_0001, 6'd10, 32'h0000_0000);

    // Branch compares, c is the target
    cmp_row("beq",      ALU_EQ,  32'h0000_1234, 32'h0000_1234, 32'h0000_0100, 1'b1);
    cmp_row("beq_miss", ALU_EQ,  32'h0000_0003, 32'h0000_0004, 32'h0000_0104, 1'b0);
    cmp_row("bne",      ALU_NE,  32'h0000_0001, 32'h0000_0002, 32'h0000_0200, 1'b1);
    cmp_row("bge",      ALU_GE,  32'hffff_fffe, 32'h0000_0001, 32'h0000_0300, 1'b0);
    cmp_row("bgeu",     ALU_GEU, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0400, 1'b1);

    //////////////////////////////
    // Multiplier
    //////////////////////////////
    mult_row("mul_halves", 32'h0001_0003, 32'h0002_0005, 0, 32'h000b_000f);
    mult_row("mul_neg",    32'hffff_ffff, 32'h0000_0003, 0, 32'hffff_fffd);
    mult_row("mul_shift",  32'h1234_5678, 32'h0000_0010, 0, 32'h2345_6780);
    rand_mult_row("mul_rand0", 0);
    rand_mult_row("mul_rand1", 0);
    // Back-pressure while the product waits in step two
    mult_row("mul_stall",  32'h0000_0007, 32'h0000_0009, 4, 32'h0000_003f);
    rand_mult_row("mul_rand_stall", 3);

    // CSR read wins over the ALU result
    csr_row("csr", 32'h0000_0001, 32'h0000_0002, 32'hc0de_0001, 6'd9);
    load_row("load",     6'd12, 32'hdead_beef, 1'b0);
    load_row("load_err", 6'd13, 32'h0bad_f00d, 1'b1);
  endtask

// ==== dv/ex_stage_tb.sv ====
// Testbench for the execute stage, table-driven over ALU, multiply, CSR, load and branch
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

  typedef enum logic [2:0] {
    K_ALU,
    K_MULT,
    K_CSR,
    K_LOAD,
    K_BRANCH
  } kind_e;

  // Operands travel in req for every kind of row
  typedef struct packed {
    kind_e      kind;
    logic       use_rand;
    alu_req_t   req;
    rf_dest_t   dest;
    word_t      data;      // CSR read data or load data
    logic       err;
    logic [3:0] stall;     // Cycles with WB not ready
    word_t      exp_data;
    logic       exp_cmp;
  } row_t;

  row_t  rows[$];
  string names[$];

  logic      clk = 1'b0;
  logic      rst_n;
  logic      alu_en_i;
  alu_req_t  alu_req_i;
  logic      mult_en_i;
  mult_req_t mult_req_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      lsu_en_i;
  logic      branch_in_ex_i;
  rf_dest_t  alu_dest_i;
  rf_dest_t  lsu_dest_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  logic      wb_ready_i;
  rf_wr_t    fw_o;
  rf_wr_t    wb_o;
  word_t     jump_target_o;
  logic      branch_decision_o;
  logic      mult_multicycle_o;
  logic      ex_ready_o;
  logic      ex_valid_o;

  int seed = 32'ha165_d21a;
  int mismatches = 0;
  int failures = 0;

  always #20 clk = ~clk;

  ex_stage dut0 (.*);

  //////////////////////////////
  // Table builders
  //////////////////////////////
  task automatic push_row(input string name, input row_t r);
    names.push_back(name);
    rows.push_back(r);
  endtask

  task automatic alu_row(input string name, input alu_op_e op, input word_t a, input word_t b,
                         input reg_addr_t addr, input word_t exp);
    row_t r;
    r = '0;
    r.kind = K_ALU;
    r.req.op = op;
    r.req.a = a;
    r.req.b = b;
    r.dest = '{we: 1'b1, addr: addr};
    r.exp_data = exp;
    push_row(name, r);
  endtask

  // Compare operators also return their bit as the ALU result
  task automatic cmp_row(input string name, input alu_op_e op, input word_t a, input word_t b,
                         input word_t c, input logic exp);
    row_t r;
    r = '0;
    r.kind = K_BRANCH;
    r.req = '{op: op, a: a, b: b, c: c};
    r.exp_cmp = exp;
    r.exp_data = exp ? 32'd1 : 32'd0;
    push_row(name, r);
  endtask

  task automatic mult_row(input string name, input word_t a, input word_t b, input int stall,
                          input word_t exp);
    row_t r;
    r = '0;
    r.kind = K_MULT;
    r.req.a = a;
    r.req.b = b;
    r.stall = stall[3:0];
    r.dest = '{we: 1'b1, addr: 6'd40};
    r.exp_data = exp;
    push_row(name, r);
  endtask

  // Operands and product are filled in when the row runs
  task automatic rand_mult_row(input string name, input int stall);
    mult_row(name, '0, '0, stall, '0);
    rows[rows.size()-1].use_rand = 1'b1;
  endtask

  task automatic csr_row(input string name, input word_t a, input word_t b, input word_t csr,
                         input reg_addr_t addr);
    row_t r;
    r = '0;
    r.kind = K_CSR;
    r.req.a = a;
    r.req.b = b;
    r.data = csr;
    r.dest = '{we: 1'b1, addr: addr};
    r.exp_data = csr;
    push_row(name, r);
  endtask

  task automatic load_row(input string name, input reg_addr_t addr, input word_t data,
                          input logic err);
    row_t r;
    r = '0;
    r.kind = K_LOAD;
    r.dest = '{we: 1'b1, addr: addr};
    r.data = data;
    r.err = err;
    push_row(name, r);
  endtask

  `include "ex_stage_tb_table.svh"

  //////////////////////////////
  // Input drivers
  //////////////////////////////

  // Load data stays put since WB reads it one cycle later
  task automatic drive_idle();
    alu_en_i = 1'b0;
    alu_req_i = '0;
    mult_en_i = 1'b0;
    mult_req_i = '0;
    csr_access_i = 1'b0;
    csr_rdata_i = '0;
    lsu_en_i = 1'b0;
    branch_in_ex_i = 1'b0;
    alu_dest_i = '0;
    lsu_dest_i = '0;
    lsu_ready_ex_i = 1'b1;
    lsu_err_i = 1'b0;
    wb_ready_i = 1'b1;
  endtask

  task automatic apply_row(input row_t r);
    wb_ready_i = (r.stall == 4'd0);
    case (r.kind)
      K_ALU, K_BRANCH: begin
        alu_en_i = 1'b1;
        alu_req_i = r.req;
        alu_dest_i = r.dest;
        branch_in_ex_i = (r.kind == K_BRANCH);
        // LSU stall leaves only the branch to raise ready
        lsu_ready_ex_i = (r.kind != K_BRANCH);
      end
      K_MULT: begin
        mult_en_i = 1'b1;
        mult_req_i = '{a: r.req.a, b: r.req.b};
        alu_dest_i = r.dest;
      end
      K_CSR: begin
        alu_en_i = 1'b1;
        alu_req_i = r.req;
        csr_access_i = 1'b1;
        csr_rdata_i = r.data;
        alu_dest_i = r.dest;
      end
      default: begin
        lsu_en_i = 1'b1;
        lsu_dest_i = r.dest;
        lsu_err_i = r.err;
        lsu_rdata_i = r.data;
      end
    endcase
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    row_t  r;
    string name;
    int    waited;
    int    exp_wait;
    logic  done;

    rst_n = 1'b0;
    lsu_rdata_i = '0;
    drive_idle();
    build_table();

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    if (wb_o.we !== 1'b0 || mult_multicycle_o !== 1'b0 || ex_ready_o !== 1'b1) begin
      failures++;
      $display("Reset left the load port write or a stage stall active");
    end

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      name = names[i];
      // Expected product is the low word of a times b
      if (r.use_rand) begin
        r.req.a = $random(seed);
        r.req.b = $random(seed);
        r.exp_data = r.req.a * r.req.b;
      end
      exp_wait = (r.kind == K_MULT && r.stall == 4'd0) ? 1 : 0;

      @(negedge clk);
      apply_row(r);
      #1;
      if (r.kind == K_MULT) begin
        if (ex_valid_o !== 1'b0 || ex_ready_o !== 1'b0 || mult_multicycle_o !== 1'b1) begin
          failures++;
          $display("%s: first multiply cycle did not stall the stage", name);
        end
      end

      // Hold WB back and release it on the last falling edge
      for (int s = 0; s < int'(r.stall); s++) begin
        if (ex_valid_o !== 1'b0 || ex_ready_o !== 1'b0) begin
          failures++;
          $display("%s: ready or valid went high while WB was stalled", name);
        end
        @(negedge clk);
        if (s == int'(r.stall) - 1) begin
          wb_ready_i = 1'b1;
        end
        #1;
      end

      waited = 0;
      done = (r.kind == K_BRANCH) ? ex_ready_o : ex_valid_o;
      while (done !== 1'b1 && waited < 20) begin
        @(negedge clk);
        #1;
        waited++;
        done = (r.kind == K_BRANCH) ? ex_ready_o : ex_valid_o;
      end

      if (done !== 1'b1) begin
        failures++;
        $display("%s: stage output never became ready or valid within 20 cycles", name);
      end else begin
        if (waited != exp_wait) begin
          mismatches++;
          $display("mismatch %s cycles: expected %0d, actual %0d", name, exp_wait, waited);
        end
        if (r.kind == K_BRANCH) begin
          if (ex_valid_o !== 1'b0) begin
            failures++;
            $display("%s: valid went high while the LSU was not ready", name);
          end
          if (branch_decision_o !== r.exp_cmp) begin
            mismatches++;
            $display("mismatch %s branch: expected %b, actual %b", name, r.exp_cmp,
                     branch_decision_o);
          end
          if (jump_target_o !== r.req.c) begin
            mismatches++;
            $display("mismatch %s target: expected %h, actual %h", name, r.req.c,
                     jump_target_o);
          end
        end
        if (r.kind != K_LOAD) begin
          if (fw_o.data !== r.exp_data) begin
            mismatches++;
            $display("mismatch %s data: expected %h, actual %h", name, r.exp_data, fw_o.data);
          end
          if (fw_o.we !== r.dest.we || fw_o.addr !== r.dest.addr) begin
            mismatches++;
            $display("mismatch %s dest: expected %h, actual %h", name, r.dest,
                     {fw_o.we, fw_o.addr});
          end
        end
      end

      // Load write shows up the cycle after valid
      @(negedge clk);
      drive_idle();
      #1;
      if (r.kind == K_LOAD) begin
        if (wb_o.we !== (r.dest.we & ~r.err)) begin
          mismatches++;
          $display("mismatch %s wb we: expected %b, actual %b", name, r.dest.we & ~r.err,
                   wb_o.we);
        end
        if (!r.err && wb_o.addr !== r.dest.addr) begin
          mismatches++;
          $display("mismatch %s wb addr: expected %h, actual %h", name, r.dest.addr,
                   wb_o.addr);
        end
        if (wb_o.data !== r.data) begin
          mismatches++;
          $display("mismatch %s wb data: expected %h, actual %h", name, r.data, wb_o.data);
        end
      end
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== ex_stage.f ====
+incdir+dv
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_wb_ports.sv
source/ex_stage.sv
dv/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ex_stage_tb -f ex_stage.f \
  --Mdir obj_dir -o ex_stage_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/ex_stage_sim > sim.log 2>&1 \
  && grep -qx "Regression passed" sim.log \
  && { echo "Simulation PASS"; exit 0; } \
  || { echo "Simulation FAIL, see sim.log"; exit 1; }
